//--- hist_bank.sv
`timescale 1ns/1ps
`include "hist_cfg.svh"

module hist_bank (
    input  logic                    clk,
    input  logic                    res,
    hist_wr_if.bank                 wr,
    input  hist_data_pkg::ram_idx_t rd_idx,
    output hist_data_pkg::count_t   rd_data
);
    import hist_data_pkg::*;

    // one count per bin of every pixel
    count_t mem [`HIST_RAM_DEPTH];
    count_t cur;
    count_t nxt;

    // read-modify-write of the addressed bin
    assign cur = mem[wr.ram_idx];
    // wraps at the count width
    assign nxt = cur + 1'b1;

    // register array, cleared by reset or by the clear strobe
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < `HIST_RAM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr.clear) begin
            // whole bank in one cycle
            for (int i = 0; i < `HIST_RAM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr.wr_en) begin
            mem[wr.ram_idx] <= nxt;
        end
    end

    // new count back to the sequencer side
    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            wr.count <= nxt;
        end
    end

    // registered read port, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_idx];
    end

endmodule

//--- hist_cfg.svh
`ifndef HIST_CFG_SVH
`define HIST_CFG_SVH

// bin address width, one TDC code per bin
`define HIST_NB 3

// bins per pixel histogram
`define HIST_BINS 8

// events taken per pixel before stepping on
`define HIST_DATA_NUM 2

// pixels held in one bank
`define HIST_PIXELS 4

// passes over all pixels per frame
`define HIST_ACQ_NUM 3

// bin count width, wraps on overflow
`define HIST_CNT_W 8

// entries per bank, bins of all pixels
`define HIST_RAM_DEPTH (`HIST_BINS * `HIST_PIXELS)

`endif

//--- hist_data_pkg.sv
`include "hist_cfg.svh"

package hist_data_pkg;

    // tdc bin address of one event
    typedef logic [`HIST_NB-1:0] bin_t;

    // histogram bin count
    typedef logic [`HIST_CNT_W-1:0] count_t;

    // flat bank index, pixel * bins + bin
    typedef logic [$clog2(`HIST_RAM_DEPTH)-1:0] ram_idx_t;

    // pixel number inside a bank
    typedef logic [$clog2(`HIST_PIXELS)-1:0] pixel_t;

endpackage

//--- hist_peak_merge.sv
`timescale 1ns/1ps
`include "hist_cfg.svh"

module hist_peak_merge (
    input  logic                     clk,
    input  logic                     res,
    input  logic                     rd_en,
    input  hist_data_pkg::pixel_t    rd_pixel,
    input  hist_seq_pkg::bank_sel_t  his_num,
    input  hist_data_pkg::count_t    rd_data0,
    input  hist_data_pkg::count_t    rd_data1,
    output hist_data_pkg::ram_idx_t  rd_idx,
    output hist_data_pkg::bin_t      peak_bin,
    output hist_data_pkg::count_t    peak_count,
    output logic                     rd_valid
);
    import hist_data_pkg::*;

    logic   issue;
    logic   data_vld;
    logic   scan_busy;
    pixel_t pix;
    bin_t   bin_cnt;
    bin_t   data_bin;
    count_t data;
    logic   data_last;

    // idle bank holds the finished frame
    assign data = (his_num == 1'b0) ? rd_data1 : rd_data0;

    // same address to both banks
    assign rd_idx = ram_idx_t'(pix) * ram_idx_t'(`HIST_BINS) + ram_idx_t'(bin_cnt);

    // busy from first address until the last compare
    assign scan_busy = issue || data_vld;
    assign data_last = data_vld && (data_bin == bin_t'(`HIST_BINS - 1));

    // address phase, one bin per cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            issue   <= 1'b0;
            bin_cnt <= '0;
            pix     <= '0;
        end else if (!scan_busy && rd_en) begin
            issue   <= 1'b1;
            bin_cnt <= '0;
            pix     <= rd_pixel;
        end else if (issue) begin
            bin_cnt <= bin_cnt + 1'b1;
            if (bin_cnt == bin_t'(`HIST_BINS - 1)) begin
                issue <= 1'b0;
            end
        end
    end

    // data phase trails the address by the read latency
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            data_vld <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            data_vld <= issue;
            rd_valid <= data_last;
        end
    end

    always_ff @(posedge clk) begin
        data_bin <= bin_cnt;
    end

    // running maximum, bin 0 seeds it
    // strict compare keeps the lowest bin on a tie
    always_ff @(posedge clk) begin
        if (data_vld) begin
            if ((data_bin == '0) || (data > peak_count)) begin
                peak_count <= data;
                peak_bin   <= data_bin;
            end
        end
    end

endmodule

//--- hist_seq_pkg.sv
`include "hist_cfg.svh"

package hist_seq_pkg;

    // events seen on the current pixel
    typedef logic [$clog2(`HIST_DATA_NUM)-1:0] ev_cnt_t;

    // acquisition pass inside the frame
    typedef logic [$clog2(`HIST_ACQ_NUM)-1:0] acq_cnt_t;

    // where the next event lands within a frame
    typedef struct packed {
        ev_cnt_t               ev;
        hist_data_pkg::pixel_t pixel;
        acq_cnt_t              acq;
    } frame_pos_t;

    // number of the bank taking writes
    typedef logic bank_sel_t;

endpackage

//--- hist_sequencer.sv
`timescale 1ns/1ps
`include "hist_cfg.svh"

module hist_sequencer (
    input  logic                     clk,
    input  logic                     res,
    input  logic                     ev_strobe,
    input  hist_data_pkg::bin_t      ev_bin,
    hist_wr_if.sequencer             wr0,
    hist_wr_if.sequencer             wr1,
    output hist_seq_pkg::bank_sel_t  his_num,
    output logic                     frame_done
);
    import hist_data_pkg::*;
    import hist_seq_pkg::*;

    frame_pos_t pos;
    ram_idx_t   idx;
    logic       ev_last;
    logic       pix_last;
    logic       acq_last;
    logic       frame_last;

    // wrap points of the three nested counters
    assign ev_last    = (pos.ev == ev_cnt_t'(`HIST_DATA_NUM - 1));
    assign pix_last   = (pos.pixel == pixel_t'(`HIST_PIXELS - 1));
    assign acq_last   = (pos.acq == acq_cnt_t'(`HIST_ACQ_NUM - 1));
    assign frame_last = ev_last && pix_last && acq_last;

    // bins of one pixel sit next to each other
    assign idx = ram_idx_t'(pos.pixel) * ram_idx_t'(`HIST_BINS) + ram_idx_t'(ev_bin);

    // both banks see the index, only the active one gets the strobe
    assign wr0.ram_idx = idx;
    assign wr1.ram_idx = idx;
    assign wr0.wr_en   = ev_strobe && (his_num == 1'b0);
    assign wr1.wr_en   = ev_strobe && (his_num == 1'b1);

    // last event of a frame wipes the bank that takes over
    assign wr0.clear = ev_strobe && frame_last && (his_num == 1'b1);
    assign wr1.clear = ev_strobe && frame_last && (his_num == 1'b0);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            pos        <= '0;
            his_num    <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= ev_strobe && frame_last;
            if (ev_strobe) begin
                if (!ev_last) begin
                    pos.ev <= pos.ev + 1'b1;
                end else begin
                    pos.ev <= '0;
                    if (!pix_last) begin
                        pos.pixel <= pos.pixel + 1'b1;
                    end else begin
                        pos.pixel <= '0;
                        if (!acq_last) begin
                            pos.acq <= pos.acq + 1'b1;
                        end else begin
                            // frame complete, swap banks
                            pos.acq <= '0;
                            his_num <= ~his_num;
                        end
                    end
                end
            end
        end
    end

endmodule

//--- hist_stimulus.txt
# W b0 b1 ... : one event per listed bin, in order
# R pixel bin count : readout with expected peak bin and count, F : wait for frame_done
W 3 3 5 1 0 7 2 2
W 3 4 5 1 7 0 6 6
W 4 3 1 6 4 4 2 6
F
R 0 3 4
R 1 1 3
R 2 0 2
R 3 2 3
# second frame goes to bank 1, first frame stays readable
W 1 1 2 2 3 3 4 4
R 0 3 4
R 2 0 2
W 1 2 2 3 3 4 4 5
R 1 1 3
R 3 2 3
W 0 0 0 0 0 0 0 0
F
R 0 1 3
R 1 2 3
R 2 3 3
R 3 4 3
# third frame restarts bank 0 from zero
W 3 3 5 1
R 0 1 3

//--- hist_top.sv
`timescale 1ns/1ps

module hist_top (
    input  logic                     clk,
    input  logic                     res,
    input  logic                     wr_en,
    input  hist_data_pkg::bin_t      addr,
    output hist_data_pkg::count_t    bin_count,
    output logic                     cnt_valid,
    output hist_seq_pkg::bank_sel_t  his_num,
    output logic                     frame_done,
    input  logic                     rd_en,
    input  hist_data_pkg::pixel_t    rd_pixel,
    output hist_data_pkg::bin_t      peak_bin,
    output hist_data_pkg::count_t    peak_count,
    output logic                     rd_valid
);
    import hist_data_pkg::*;
    import hist_seq_pkg::*;

    ram_idx_t  rd_idx;
    count_t    rd_data0;
    count_t    rd_data1;
    // bank that took the last event
    bank_sel_t cnt_bank;

    // write and clear traffic, one per bank
    hist_wr_if wr0 ();
    hist_wr_if wr1 ();

    hist_sequencer u_seq (
        .clk        (clk),
        .res        (res),
        .ev_strobe  (wr_en),
        .ev_bin     (addr),
        .wr0        (wr0.sequencer),
        .wr1        (wr1.sequencer),
        .his_num    (his_num),
        .frame_done (frame_done)
    );

    hist_bank u_bank0 (
        .clk     (clk),
        .res     (res),
        .wr      (wr0.bank),
        .rd_idx  (rd_idx),
        .rd_data (rd_data0)
    );

    hist_bank u_bank1 (
        .clk     (clk),
        .res     (res),
        .wr      (wr1.bank),
        .rd_idx  (rd_idx),
        .rd_data (rd_data1)
    );

    hist_peak_merge u_peak (
        .clk        (clk),
        .res        (res),
        .rd_en      (rd_en),
        .rd_pixel   (rd_pixel),
        .his_num    (his_num),
        .rd_data0   (rd_data0),
        .rd_data1   (rd_data1),
        .rd_idx     (rd_idx),
        .peak_bin   (peak_bin),
        .peak_count (peak_count),
        .rd_valid   (rd_valid)
    );

    // his_num flips on the final event, so remember the written bank
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            cnt_valid <= 1'b0;
            cnt_bank  <= 1'b0;
        end else begin
            cnt_valid <= wr_en;
            if (wr_en) begin
                cnt_bank <= his_num;
            end
        end
    end

    // count of the bank that took the event
    assign bin_count = (cnt_bank == 1'b0) ? wr0.count : wr1.count;

endmodule

//--- hist_wr_if.sv
`timescale 1ns/1ps

interface hist_wr_if;
    import hist_data_pkg::*;

    // increment strobe for the addressed entry
    logic     wr_en;
    // entry to increment
    ram_idx_t ram_idx;
    // zero the whole bank
    logic     clear;
    // post-increment value, one cycle after wr_en
    count_t   count;

    modport sequencer (
        output wr_en,
        output ram_idx,
        output clear,
        input  count
    );

    modport bank (
        input  wr_en,
        input  ram_idx,
        input  clear,
        output count
    );

endinterface

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_hist -o tb_hist
./obj_dir/tb_hist | tee sim.log

if grep -q "^sim passed$" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

//--- src.f
+incdir+.
hist_data_pkg.sv
hist_seq_pkg.sv
hist_wr_if.sv
hist_sequencer.sv
hist_bank.sv
hist_peak_merge.sv
hist_top.sv
tb_hist_check.sv
tb_hist.sv

//--- tb_hist.sv
`timescale 1ns/1ps
`include "hist_cfg.svh"

module tb_hist;
    import hist_data_pkg::*;
    import hist_seq_pkg::*;

    // cycles allowed for any single wait
    localparam int WAIT_LIMIT = 200;

    logic      clk;
    logic      res;
    logic      wr_en;
    bin_t      addr;
    count_t    bin_count;
    logic      cnt_valid;
    bank_sel_t his_num;
    logic      frame_done;
    logic      rd_en;
    pixel_t    rd_pixel;
    bin_t      peak_bin;
    count_t    peak_count;
    logic      rd_valid;
    // expected peak handed to the checker with rd_en
    bin_t      exp_bin;
    count_t    exp_count;
    int        errors;
    int        checks;
    // failures other than wrong values
    int        faults;
    int        frames_seen = 0;
    int        frames_used;

    hist_top i_dut (
        .clk        (clk),
        .res        (res),
        .wr_en      (wr_en),
        .addr       (addr),
        .bin_count  (bin_count),
        .cnt_valid  (cnt_valid),
        .his_num    (his_num),
        .frame_done (frame_done),
        .rd_en      (rd_en),
        .rd_pixel   (rd_pixel),
        .peak_bin   (peak_bin),
        .peak_count (peak_count),
        .rd_valid   (rd_valid)
    );

    tb_hist_check i_chk (
        .clk        (clk),
        .res        (res),
        .wr_en      (wr_en),
        .addr       (addr),
        .bin_count  (bin_count),
        .cnt_valid  (cnt_valid),
        .his_num    (his_num),
        .frame_done (frame_done),
        .rd_en      (rd_en),
        .rd_pixel   (rd_pixel),
        .peak_bin   (peak_bin),
        .peak_count (peak_count),
        .rd_valid   (rd_valid),
        .exp_bin    (exp_bin),
        .exp_count  (exp_count),
        .errors     (errors),
        .checks     (checks)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // frame_done is a single-cycle pulse, keep a tally
    always @(posedge clk) begin
        if (res && frame_done) begin
            frames_seen++;
        end
    end

    // random idle gap, then one event
    task automatic send_event(input int bin);
        int gap;
        gap = int'($urandom % 3);
        repeat (gap) begin
            @(posedge clk);
            #2;
        end
        addr  = bin_t'(bin);
        wr_en = 1'b1;
        @(posedge clk);
        #2;
        wr_en = 1'b0;
    endtask

    task automatic read_peak(input int pixel, input int bin, input int count);
        int n;
        rd_pixel  = pixel_t'(pixel);
        exp_bin   = bin_t'(bin);
        exp_count = count_t'(count);
        rd_en     = 1'b1;
        @(posedge clk);
        #2;
        rd_en = 1'b0;
        n = 0;
        while (!rd_valid && n < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!rd_valid) begin
            $display("timeout waiting for rd_valid on readout of pixel %0d", pixel);
            faults++;
        end
    endtask

    task automatic wait_frame();
        int n;
        n = 0;
        while (frames_seen <= frames_used && n < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (frames_seen > frames_used) begin
            frames_used++;
        end else begin
            $display("timeout waiting for frame_done");
            faults++;
        end
    endtask

    initial begin
        string line;
        byte   cmd;
        int    v [8];
        int    n;
        int    fd;
        void'($urandom(24774));
        res         = 1'b0;
        wr_en       = 1'b0;
        addr        = '0;
        rd_en       = 1'b0;
        rd_pixel    = '0;
        exp_bin     = '0;
        exp_count   = '0;
        faults      = 0;
        frames_used = 0;
        repeat (2) @(posedge clk);
        #2;
        res = 1'b1;
        fd  = $fopen("hist_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open hist_stimulus.txt");
            faults++;
        end else begin
            while (faults == 0 && $fgets(line, fd) != 0) begin
                n = $sscanf(line, "%c %d %d %d %d %d %d %d %d", cmd,
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                if (n < 1 || cmd == "#" || cmd == "\n") begin
                    // blank or comment line
                end else if (cmd == "W") begin
                    for (int i = 0; i < n - 1; i++) begin
                        send_event(v[i]);
                    end
                end else if (cmd == "R" && n == 4) begin
                    read_peak(v[0], v[1], v[2]);
                end else if (cmd == "F") begin
                    wait_frame();
                end else begin
                    $display("unreadable line in stimulus file: %s", line);
                    faults++;
                end
            end
            $fclose(fd);
        end
        // last outputs still reach the checker
        repeat (3) @(posedge clk);
        $display("checks %0d errors %0d other failures %0d", checks, errors, faults);
        if (errors != 0 || faults != 0) begin
            $display("sim failed");
        end else begin
            $display("sim passed");
        end
        $finish;
    end

endmodule

//--- tb_hist_check.sv
`timescale 1ns/1ps
`include "hist_cfg.svh"

module tb_hist_check (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    wr_en,
    input  hist_data_pkg::bin_t     addr,
    input  hist_data_pkg::count_t   bin_count,
    input  logic                    cnt_valid,
    input  hist_seq_pkg::bank_sel_t his_num,
    input  logic                    frame_done,
    input  logic                    rd_en,
    input  hist_data_pkg::pixel_t   rd_pixel,
    input  hist_data_pkg::bin_t     peak_bin,
    input  hist_data_pkg::count_t   peak_count,
    input  logic                    rd_valid,
    input  hist_data_pkg::bin_t     exp_bin,
    input  hist_data_pkg::count_t   exp_count,
    output int                      errors,
    output int                      checks
);
    import hist_data_pkg::*;

    // reference counts per bank, pixel and bin
    int    model [2][`HIST_PIXELS][`HIST_BINS];
    // active bank and frame position of the next event
    int    bank;
    int    ev;
    int    pix;
    int    acq;
    // expected bin_count after the last edge, -1 when none
    int    pend_cnt;
    string pend_name;
    bit    pend_frame;
    // cycles since an accepted rd_en, -1 while idle
    int    scan_age;
    int    scan_pix;
    int    want_bin;
    int    want_cnt;

    task automatic compare(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("Error: %s expected %0d actual %0d at %0t", name, exp, act, $time);
        end
    endtask

    task automatic reset_model();
        foreach (model[b, p, i]) begin
            model[b][p][i] = 0;
        end
        bank       = 0;
        ev         = 0;
        pix        = 0;
        acq        = 0;
        pend_cnt   = -1;
        pend_frame = 1'b0;
        scan_age   = -1;
        errors     = 0;
        checks     = 0;
    endtask

    // one event into the active bank, counters nest event, pixel, acquisition
    task automatic take_event();
        pend_cnt   = -1;
        pend_frame = 1'b0;
        if (wr_en) begin
            model[bank][pix][addr] = (model[bank][pix][addr] + 1) % (1 << `HIST_CNT_W);
            pend_cnt  = model[bank][pix][addr];
            pend_name = $sformatf("bin_count px%0d bin%0d", pix, addr);
            ev++;
            if (ev == `HIST_DATA_NUM) begin
                ev = 0;
                pix++;
            end
            if (pix == `HIST_PIXELS) begin
                pix = 0;
                acq++;
            end
            if (acq == `HIST_ACQ_NUM) begin
                // frame end, new bank starts empty
                acq        = 0;
                bank       = 1 - bank;
                pend_frame = 1'b1;
                for (int p = 0; p < `HIST_PIXELS; p++) begin
                    for (int i = 0; i < `HIST_BINS; i++) begin
                        model[bank][p][i] = 0;
                    end
                end
            end
        end
    endtask

    // rd_valid only at the end of a scan
    task automatic track_scan();
        if (scan_age >= 0) begin
            scan_age++;
            if (scan_age == `HIST_BINS + 2) begin
                compare("rd_valid", 1, int'(rd_valid));
                compare($sformatf("peak_bin px%0d", scan_pix), want_bin, int'(peak_bin));
                compare($sformatf("peak_count px%0d", scan_pix), want_cnt, int'(peak_count));
                scan_age = -1;
            end else begin
                compare("rd_valid during scan", 0, int'(rd_valid));
            end
        end else begin
            compare("rd_valid idle", 0, int'(rd_valid));
        end
        // ignored while a scan runs
        if (rd_en && scan_age < 0) begin
            scan_age = 0;
            scan_pix = int'(rd_pixel);
            want_bin = int'(exp_bin);
            want_cnt = int'(exp_count);
        end
    endtask

    always @(posedge clk) begin
        if (!res) begin
            reset_model();
        end else begin
            // outputs reflect the previous edge
            if (pend_cnt >= 0) begin
                compare("cnt_valid", 1, int'(cnt_valid));
                compare(pend_name, pend_cnt, int'(bin_count));
            end else begin
                compare("cnt_valid idle", 0, int'(cnt_valid));
            end
            compare("frame_done", int'(pend_frame), int'(frame_done));
            compare("his_num", bank, int'(his_num));
            track_scan();
            take_event();
        end
    end

endmodule
